// ==== build.f ====
rtl/rv_pkg.sv
rtl/id_pkg.sv
rtl/ctrl_unit.sv
rtl/reg_file.sv
rtl/operand_forward.sv
rtl/branch_unit.sv
rtl/id_stage.sv
tb/clk_gen.sv
tb/id_stage_assert.sv
tb/id_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module id_stage_tb -f build.f -o sim_id_stage \
    || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/sim_id_stage)
echo "$out"
echo "$out" | grep -q "Result: PASSED" && exit 0 || exit 1

// ==== tb/id_stage_tb.sv ====
`timescale 1ns/1ps

module id_stage_tb;

    localparam int PRELOAD_CYCLES = 8;

    typedef struct packed {
        rv_pkg::inst_t   inst;
        rv_pkg::xlen_t   pc;
        id_pkg::byp_t    ex;
        id_pkg::byp_t    mem;
        id_pkg::byp_t    wb;
        logic            chk_ops;
        rv_pkg::xlen_t   src1;
        rv_pkg::xlen_t   src2;
        logic            rf_we;
        logic            stall;
        logic            redirect;
        rv_pkg::xlen_t   redirect_pc;
        logic            mem_en;
        logic            mem_wen;
        logic [2:0]      mem_size;
        logic            load;
        rv_pkg::xlen_t   store_data;
        id_pkg::alu_op_e alu_op;
    } entry_t;

    logic          clk;
    logic          rst_n;
    rv_pkg::xlen_t pc;
    rv_pkg::inst_t inst;
    id_pkg::byp_t  ex_byp;
    id_pkg::byp_t  mem_byp;
    id_pkg::byp_t  wb_byp;
    id_pkg::ctrl_t ctrl;
    rv_pkg::xlen_t alu_src1;
    rv_pkg::xlen_t alu_src2;
    rv_pkg::xlen_t store_data;
    logic          redirect;
    rv_pkg::xlen_t redirect_pc;
    logic          stall;

    rv_pkg::xlen_t model [0:31];
    rv_pkg::xlen_t preload [1:PRELOAD_CYCLES];
    rv_pkg::xlen_t next_pc = 64'h8000_0000;
    entry_t        table_q [$];
    string         name_q [$];
    int            errors = 0;
    int            failed = 0;
    int            cycles = 0;
    int            limit = 1000;

    clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    id_stage i_dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .pc_i          (pc),
        .inst_i        (inst),
        .ex_byp_i      (ex_byp),
        .mem_byp_i     (mem_byp),
        .wb_byp_i      (wb_byp),
        .ctrl_o        (ctrl),
        .alu_src1_o    (alu_src1),
        .alu_src2_o    (alu_src2),
        .store_data_o  (store_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .stall_o       (stall)
    );

    function automatic rv_pkg::inst_t enc_i(rv_pkg::opcode_t op, rv_pkg::reg_addr_t rd,
                                            logic [2:0] f3, rv_pkg::reg_addr_t rs1,
                                            logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::inst_t enc_s(logic [2:0] f3, rv_pkg::reg_addr_t rs1,
                                            rv_pkg::reg_addr_t rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::inst_t enc_b(logic [2:0] f3, rv_pkg::reg_addr_t rs1,
                                            rv_pkg::reg_addr_t rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::inst_t enc_u(rv_pkg::opcode_t op, rv_pkg::reg_addr_t rd,
                                            logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::inst_t enc_j(rv_pkg::reg_addr_t rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    function automatic id_pkg::byp_t byp(logic load, rv_pkg::reg_addr_t waddr,
                                         rv_pkg::xlen_t data);
        return {1'b1, load, waddr, data};
    endfunction

    function automatic rv_pkg::xlen_t rand64();
        return {$urandom(), $urandom()};
    endfunction

    // quiet buses, no memory access, no redirect
    function automatic entry_t base(rv_pkg::inst_t i, rv_pkg::xlen_t s1,
                                    rv_pkg::xlen_t s2, logic we);
        entry_t e;
        e         = '0;
        e.inst    = i;
        e.pc      = next_pc;
        e.chk_ops = 1'b1;
        e.src1    = s1;
        e.src2    = s2;
        e.rf_we   = we;
        return e;
    endfunction

    function automatic entry_t branch(logic [2:0] f3, rv_pkg::reg_addr_t a,
                                      rv_pkg::reg_addr_t b, rv_pkg::xlen_t imm,
                                      logic taken);
        entry_t e;
        e             = base(enc_b(f3, a, b, imm[12:0]), model[a], model[b], 1'b0);
        e.redirect    = taken;
        e.redirect_pc = taken ? e.pc + imm : '0;
        return e;
    endfunction

    task automatic push_entry(string name, entry_t e);
        table_q.push_back(e);
        name_q.push_back(name);
        next_pc = next_pc + 64'd4;
        // WB write lands at the end of this entry's cycle
        if (e.wb.we && e.wb.waddr != 5'd0) begin
            model[e.wb.waddr] = e.wb.data;
        end
    endtask

    task automatic expect_eq(string test, string field, rv_pkg::xlen_t got,
                             rv_pkg::xlen_t exp, inout int bad);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: %s is %h, expected %h", $time, test, field, got, exp);
            bad++;
        end
    endtask

    task automatic check_entry(int k);
        entry_t e;
        string  n;
        int     bad;
        e   = table_q[k];
        n   = name_q[k];
        bad = 0;
        if (e.chk_ops) begin
            expect_eq(n, "alu_src1_o", alu_src1, e.src1, bad);
            expect_eq(n, "alu_src2_o", alu_src2, e.src2, bad);
        end
        expect_eq(n, "rf_we", 64'(ctrl.rf_we), 64'(e.rf_we), bad);
        if (e.rf_we) begin
            expect_eq(n, "rf_waddr", 64'(ctrl.rf_waddr), 64'(e.inst[11:7]), bad);
        end
        if (e.rf_we || e.mem_en) begin
            expect_eq(n, "alu_op", 64'(ctrl.alu_op), 64'(e.alu_op), bad);
        end
        expect_eq(n, "stall_o", 64'(stall), 64'(e.stall), bad);
        expect_eq(n, "redirect_o", 64'(redirect), 64'(e.redirect), bad);
        expect_eq(n, "redirect_pc_o", redirect_pc, e.redirect_pc, bad);
        expect_eq(n, "mem_en", 64'(ctrl.mem_en), 64'(e.mem_en), bad);
        expect_eq(n, "mem_wen", 64'(ctrl.mem_wen), 64'(e.mem_wen), bad);
        expect_eq(n, "load", 64'(ctrl.load), 64'(e.load), bad);
        if (e.mem_en) begin
            expect_eq(n, "mem_size", 64'(ctrl.mem_size), 64'(e.mem_size), bad);
        end
        if (e.mem_wen && e.chk_ops) begin
            expect_eq(n, "store_data_o", store_data, e.store_data, bad);
        end
        if (bad == 0) begin
            $display("%-20s ok", n);
        end else begin
            $display("%-20s %0d mismatches", n, bad);
            failed++;
        end
        errors += bad;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        entry_t        e;
        rv_pkg::xlen_t d1;
        rv_pkg::xlen_t d2;
        rv_pkg::xlen_t d3;
        void'($urandom(66292));
        pc      = '0;
        inst    = rv_pkg::NOP_INST;
        ex_byp  = '0;
        mem_byp = '0;
        wb_byp  = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        for (int r = 1; r <= PRELOAD_CYCLES; r++) begin
            model[r] = rand64();
        end
        // x7 negative, x8 positive for the signed compares
        model[7][63] = 1'b1;
        model[8][63] = 1'b0;
        for (int r = 1; r <= PRELOAD_CYCLES; r++) begin
            preload[r] = model[r];
        end

        e = base(enc_i(rv_pkg::OPC_OP_IMM, 5'd5, 3'd0, 5'd2, 12'hFFB), model[2],
                 64'hFFFF_FFFF_FFFF_FFFB, 1'b1);
        push_entry("addi_rs", e);
        e = base(enc_i(rv_pkg::OPC_OP_IMM, 5'd5, 3'd0, 5'd0, 12'h064), 64'd0, 64'd100, 1'b1);
        e.wb = byp(1'b0, 5'd0, rand64());
        push_entry("addi_x0_write", e);
        e.wb = '0;
        push_entry("addi_x0_after", e);
        e = base(enc_u(rv_pkg::OPC_LUI, 5'd9, 20'h80000), 64'd0,
                 64'hFFFF_FFFF_8000_0000, 1'b1);
        e.alu_op = id_pkg::ALU_PASS_B;
        push_entry("lui", e);

        // EX, then MEM, then WB
        d1 = rand64();
        d2 = rand64();
        d3 = rand64();
        e = base(enc_i(rv_pkg::OPC_OP_IMM, 5'd5, 3'd0, 5'd3, 12'h001), d1, 64'd1, 1'b1);
        e.ex  = byp(1'b0, 5'd3, d1);
        e.mem = byp(1'b0, 5'd3, d2);
        e.wb  = byp(1'b0, 5'd3, d3);
        push_entry("fwd_ex_wins", e);
        e.ex   = '0;
        e.src1 = d2;
        push_entry("fwd_mem_wins", e);
        d3     = rand64();
        e.mem  = '0;
        e.wb   = byp(1'b0, 5'd3, d3);
        e.src1 = d3;
        push_entry("fwd_wb_same_cycle", e);
        e = base(enc_i(rv_pkg::OPC_OP_IMM, 5'd5, 3'd0, 5'd3, 12'h001), model[3], 64'd1, 1'b1);
        push_entry("rf_after_wb", e);

        e = base(enc_i(rv_pkg::OPC_OP_IMM, 5'd5, 3'd0, 5'd2, 12'h001), 64'd0, 64'd0, 1'b1);
        e.chk_ops = 1'b0;
        e.stall   = 1'b1;
        e.ex      = byp(1'b1, 5'd2, rand64());
        push_entry("load_use_ex", e);
        e.ex  = '0;
        e.mem = byp(1'b1, 5'd2, rand64());
        push_entry("load_use_mem", e);
        e = base(enc_s(3'b011, 5'd4, 5'd2, 12'h000), 64'd0, 64'd0, 1'b0);
        e.chk_ops  = 1'b0;
        e.stall    = 1'b1;
        e.mem_en   = 1'b1;
        e.mem_wen  = 1'b1;
        e.mem_size = 3'b011;
        e.mem      = byp(1'b1, 5'd2, rand64());
        push_entry("load_use_rs2", e);
        e = base(enc_i(rv_pkg::OPC_OP_IMM, 5'd5, 3'd0, 5'd0, 12'h001), 64'd0, 64'd1, 1'b1);
        e.ex = byp(1'b1, 5'd0, rand64());
        push_entry("load_x0_no_stall", e);
        // rs1 field of this lui decodes as x2
        e = base(enc_u(rv_pkg::OPC_LUI, 5'd9, 20'h00010), 64'd0, 64'h0001_0000, 1'b1);
        e.alu_op = id_pkg::ALU_PASS_B;
        e.ex     = byp(1'b1, 5'd2, rand64());
        push_entry("lui_no_stall", e);
        e = branch(rv_pkg::F3_BEQ, 5'd2, 5'd2, 64'd16, 1'b0);
        e.chk_ops = 1'b0;
        e.stall   = 1'b1;
        e.ex      = byp(1'b1, 5'd2, rand64());
        push_entry("branch_stalled", e);

        push_entry("beq_equal", branch(rv_pkg::F3_BEQ, 5'd3, 5'd3, 64'd16,
                                       model[3] == model[3]));
        push_entry("beq_differ", branch(rv_pkg::F3_BEQ, 5'd1, 5'd2,
                                        64'hFFFF_FFFF_FFFF_FFE0, model[1] == model[2]));
        push_entry("bne", branch(rv_pkg::F3_BNE, 5'd1, 5'd2, 64'd8, model[1] != model[2]));
        push_entry("blt_neg_pos", branch(rv_pkg::F3_BLT, 5'd7, 5'd8, 64'hFFFF_FFFF_FFFF_FFF0,
                                         $signed(model[7]) < $signed(model[8])));
        push_entry("blt_pos_neg", branch(rv_pkg::F3_BLT, 5'd8, 5'd7, 64'd32,
                                         $signed(model[8]) < $signed(model[7])));
        push_entry("bltu_big_small", branch(rv_pkg::F3_BLTU, 5'd7, 5'd8, 64'd24,
                                            model[7] < model[8]));
        push_entry("bltu_small_big", branch(rv_pkg::F3_BLTU, 5'd8, 5'd7, 64'd40,
                                            model[8] < model[7]));

        e = base(enc_j(5'd1, 21'h1FFFC0), next_pc, 64'd4, 1'b1);
        e.redirect    = 1'b1;
        e.redirect_pc = next_pc - 64'd64;
        push_entry("jal_back", e);
        e = base(enc_i(rv_pkg::OPC_JALR, 5'd1, 3'd0, 5'd4, 12'h00D), next_pc, 64'd4, 1'b1);
        e.redirect    = 1'b1;
        e.redirect_pc = (model[4] + 64'd13) & ~64'd1;
        push_entry("jalr_odd", e);

        e = base(enc_i(rv_pkg::OPC_LOAD, 5'd5, 3'b010, 5'd1, 12'hFFC), model[1],
                 64'hFFFF_FFFF_FFFF_FFFC, 1'b1);
        e.mem_en   = 1'b1;
        e.mem_size = 3'b010;
        e.load     = 1'b1;
        push_entry("lw", e);
        e = base(enc_s(3'b011, 5'd4, 5'd3, 12'h008), model[4], 64'd8, 1'b0);
        e.mem_en     = 1'b1;
        e.mem_wen    = 1'b1;
        e.mem_size   = 3'b011;
        e.store_data = model[3];
        push_entry("sd", e);
        e = base(enc_s(3'b000, 5'd5, 5'd6, 12'hFFF), model[5], 64'hFFFF_FFFF_FFFF_FFFF, 1'b0);
        e.mem_en     = 1'b1;
        e.mem_wen    = 1'b1;
        e.store_data = model[6];
        push_entry("sb_neg", e);
        e = base(32'h0000_007F, 64'd0, 64'd0, 1'b0);
        e.chk_ops = 1'b0;
        push_entry("bad_opcode", e);

        limit = table_q.size() + PRELOAD_CYCLES + 20;

        // enables that the reset gating has to hold low
        inst   = enc_s(3'b011, 5'd1, 5'd2, 12'h000);
        ex_byp = byp(1'b1, 5'd2, '0);
        @(posedge clk);
        #2;
        inst   = enc_j(5'd1, 21'h000010);
        ex_byp = '0;

        wait (rst_n === 1'b1);
        inst = rv_pkg::NOP_INST;
        for (int r = 1; r <= PRELOAD_CYCLES; r++) begin
            wb_byp = byp(1'b0, 5'(r), preload[r]);
            @(posedge clk);
            #2;
        end
        wb_byp = '0;

        foreach (table_q[k]) begin
            inst    = table_q[k].inst;
            pc      = table_q[k].pc;
            ex_byp  = table_q[k].ex;
            mem_byp = table_q[k].mem;
            wb_byp  = table_q[k].wb;
            #8;
            check_entry(k);
            @(posedge clk);
            #2;
        end

        $display("%0d tests, %0d failed, %0d mismatches", table_q.size(), failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/id_stage_assert.sv ====
`timescale 1ns/1ps

module id_stage_sva (
    input logic          clk,
    input logic          rst_n_i,
    input id_pkg::ctrl_t ctrl_o,
    input logic          redirect_o,
    input rv_pkg::xlen_t redirect_pc_o,
    input logic          stall_o
);

    // a stalled branch never redirects
    a_stall_excl_redirect: assert property (@(posedge clk) !(stall_o && redirect_o))
        else $error("stall_o and redirect_o high in the same cycle");

    a_idle_target_zero: assert property (@(posedge clk) !redirect_o |-> redirect_pc_o == '0)
        else $error("redirect_pc_o nonzero without redirect_o");

    a_reset_quiet: assert property (@(posedge clk) !rst_n_i |->
            !(ctrl_o.rf_we || ctrl_o.mem_en || ctrl_o.mem_wen || redirect_o || stall_o))
        else $error("enable set while in reset");

    // targets are halfword aligned
    a_target_aligned: assert property (@(posedge clk) redirect_o |-> !redirect_pc_o[0])
        else $error("redirect_pc_o bit 0 set");

endmodule

bind id_stage id_stage_sva u_id_stage_sva (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .ctrl_o        (ctrl_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o),
    .stall_o       (stall_o)
);

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // held low over four rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #2 rst_n_o = 1'b1;
    end

endmodule

// ==== rtl/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic          clk,
    input  logic          rst_n_i,
    input  rv_pkg::xlen_t pc_i,
    input  rv_pkg::inst_t inst_i,
    input  id_pkg::byp_t  ex_byp_i,
    input  id_pkg::byp_t  mem_byp_i,
    input  id_pkg::byp_t  wb_byp_i,
    output id_pkg::ctrl_t ctrl_o,
    output rv_pkg::xlen_t alu_src1_o,
    output rv_pkg::xlen_t alu_src2_o,
    output rv_pkg::xlen_t store_data_o,
    output logic          redirect_o,
    output rv_pkg::xlen_t redirect_pc_o,
    output logic          stall_o
);

    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::funct3_t   funct3;
    rv_pkg::xlen_t     imm;
    logic              re1;
    logic              re2;
    rv_pkg::xlen_t     port1;
    rv_pkg::xlen_t     port2;
    rv_pkg::xlen_t     fwd1;
    rv_pkg::xlen_t     fwd2;
    logic              br_redirect;
    rv_pkg::xlen_t     br_pc;

    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct3 = inst_i[14:12];

    ctrl_unit u_ctrl_unit (
        .rst_n_i (rst_n_i),
        .inst_i  (inst_i),
        .ctrl_o  (ctrl_o),
        .imm_o   (imm),
        .re1_o   (re1),
        .re2_o   (re2)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .wr_i     (wb_byp_i),
        .rdata1_o (port1),
        .rdata2_o (port2)
    );

    operand_forward u_operand_forward (
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .re1_i   (re1),
        .re2_i   (re2),
        .port1_i (port1),
        .port2_i (port2),
        .ex_i    (ex_byp_i),
        .mem_i   (mem_byp_i),
        .wb_i    (wb_byp_i),
        .fwd1_o  (fwd1),
        .fwd2_o  (fwd2),
        .stall_o (stall_o)
    );

    branch_unit u_branch_unit (
        .kind_i        (ctrl_o.br_kind),
        .funct3_i      (funct3),
        .pc_i          (pc_i),
        .imm_i         (imm),
        .op1_i         (fwd1),
        .op2_i         (fwd2),
        .redirect_o    (br_redirect),
        .redirect_pc_o (br_pc)
    );

    always_comb begin
        case (ctrl_o.src1_sel)
            id_pkg::SRC1_RS1: alu_src1_o = fwd1;
            id_pkg::SRC1_PC:  alu_src1_o = pc_i;
            default:          alu_src1_o = '0;
        endcase
        case (ctrl_o.src2_sel)
            id_pkg::SRC2_RS2:  alu_src2_o = fwd2;
            id_pkg::SRC2_IMM:  alu_src2_o = imm;
            default:           alu_src2_o = 64'd4;
        endcase
    end

    assign store_data_o = fwd2;

    // operands may be stale while stalled, so hold off the redirect
    assign redirect_o    = br_redirect && !stall_o;
    assign redirect_pc_o = redirect_o ? br_pc : '0;

endmodule

// ==== rtl/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::br_kind_e kind_i,
    input  rv_pkg::funct3_t  funct3_i,
    input  rv_pkg::xlen_t    pc_i,
    input  rv_pkg::xlen_t    imm_i,
    input  rv_pkg::xlen_t    op1_i,
    input  rv_pkg::xlen_t    op2_i,
    output logic             redirect_o,
    output rv_pkg::xlen_t    redirect_pc_o
);

    logic [64:0]   diff;
    logic          eq;
    logic          lt;
    logic          ltu;
    logic          taken;
    rv_pkg::xlen_t target;

    // borrow out gives unsigned less-than
    assign diff = {1'b0, op1_i} - {1'b0, op2_i};
    assign eq   = (diff[63:0] == '0);
    assign ltu  = diff[64];
    // signs differ: the negative one is smaller
    assign lt   = (op1_i[63] ^ op2_i[63]) ? op1_i[63] : diff[63];

    always_comb begin
        case (funct3_i)
            rv_pkg::F3_BEQ:  taken = eq;
            rv_pkg::F3_BNE:  taken = !eq;
            rv_pkg::F3_BLT:  taken = lt;
            rv_pkg::F3_BGE:  taken = !lt;
            rv_pkg::F3_BLTU: taken = ltu;
            rv_pkg::F3_BGEU: taken = !ltu;
            default:         taken = 1'b0;
        endcase
    end

    assign redirect_o = (kind_i == id_pkg::BR_JAL) || (kind_i == id_pkg::BR_JALR) ||
                        ((kind_i == id_pkg::BR_COND) && taken);

    assign target = (kind_i == id_pkg::BR_JALR) ? ((op1_i + imm_i) & ~64'd1)
                                                : (pc_i + imm_i);

    assign redirect_pc_o = redirect_o ? target : '0;

endmodule

// ==== rtl/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward (
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  logic              re1_i,
    input  logic              re2_i,
    input  rv_pkg::xlen_t     port1_i,
    input  rv_pkg::xlen_t     port2_i,
    input  id_pkg::byp_t      ex_i,
    input  id_pkg::byp_t      mem_i,
    input  id_pkg::byp_t      wb_i,
    output rv_pkg::xlen_t     fwd1_o,
    output rv_pkg::xlen_t     fwd2_o,
    output logic              stall_o
);

    function automatic logic hit(input id_pkg::byp_t b, input rv_pkg::reg_addr_t rs);
        return b.we && (b.waddr == rs) && (rs != '0);
    endfunction

    // youngest producer first
    function automatic rv_pkg::xlen_t pick(input rv_pkg::reg_addr_t rs,
                                           input rv_pkg::xlen_t port,
                                           input id_pkg::byp_t ex,
                                           input id_pkg::byp_t mem,
                                           input id_pkg::byp_t wb);
        if (hit(ex, rs)) return ex.data;
        if (hit(mem, rs)) return mem.data;
        if (hit(wb, rs)) return wb.data;
        return port;
    endfunction

    // a load that would win the priority has no data yet
    function automatic logic load_use(input rv_pkg::reg_addr_t rs,
                                      input id_pkg::byp_t ex,
                                      input id_pkg::byp_t mem);
        if (hit(ex, rs)) return ex.load;
        return hit(mem, rs) && mem.load;
    endfunction

    assign fwd1_o  = pick(rs1_i, port1_i, ex_i, mem_i, wb_i);
    assign fwd2_o  = pick(rs2_i, port2_i, ex_i, mem_i, wb_i);
    assign stall_o = (re1_i && load_use(rs1_i, ex_i, mem_i)) ||
                     (re2_i && load_use(rs2_i, ex_i, mem_i));

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n_i,
    input  rv_pkg::reg_addr_t raddr1_i,
    input  rv_pkg::reg_addr_t raddr2_i,
    input  id_pkg::byp_t      wr_i,
    output rv_pkg::xlen_t     rdata1_o,
    output rv_pkg::xlen_t     rdata2_o
);

    // x0 has no storage
    rv_pkg::xlen_t regs [31:1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.waddr != '0) begin
            regs[wr_i.waddr] <= wr_i.data;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== rtl/ctrl_unit.sv ====
`timescale 1ns/1ps

module ctrl_unit (
    input  logic          rst_n_i,
    input  rv_pkg::inst_t inst_i,
    output id_pkg::ctrl_t ctrl_o,
    output rv_pkg::xlen_t imm_o,
    output logic          re1_o,
    output logic          re2_o
);

    rv_pkg::opcode_t opcode;
    rv_pkg::funct3_t funct3;
    logic            alt;
    rv_pkg::xlen_t   imm_i;
    rv_pkg::xlen_t   imm_s;
    rv_pkg::xlen_t   imm_b;
    rv_pkg::xlen_t   imm_u;
    rv_pkg::xlen_t   imm_j;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    // funct7 bit 5 selects sub / sra
    assign alt    = inst_i[30];

    assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // shared by OP and OP-IMM, addi has no subtract form
    function automatic id_pkg::alu_op_e alu_dec(input rv_pkg::funct3_t f3,
                                                input logic alt_b,
                                                input logic is_reg);
        case (f3)
            3'b000:  return (alt_b && is_reg) ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
            3'b001:  return id_pkg::ALU_SLL;
            3'b010:  return id_pkg::ALU_SLT;
            3'b011:  return id_pkg::ALU_SLTU;
            3'b100:  return id_pkg::ALU_XOR;
            3'b101:  return alt_b ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
            3'b110:  return id_pkg::ALU_OR;
            default: return id_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        // bubble unless a supported opcode matches
        ctrl_o          = '0;
        ctrl_o.alu_op   = id_pkg::ALU_ADD;
        ctrl_o.src1_sel = id_pkg::SRC1_RS1;
        ctrl_o.src2_sel = id_pkg::SRC2_IMM;
        ctrl_o.br_kind  = id_pkg::BR_NONE;
        ctrl_o.mem_size = funct3;
        ctrl_o.rf_waddr = inst_i[11:7];
        imm_o           = '0;
        re1_o           = 1'b0;
        re2_o           = 1'b0;

        case (opcode)
            rv_pkg::OPC_OP: begin
                ctrl_o.alu_op   = alu_dec(funct3, alt, 1'b1);
                ctrl_o.src2_sel = id_pkg::SRC2_RS2;
                ctrl_o.rf_we    = 1'b1;
                re1_o           = 1'b1;
                re2_o           = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                ctrl_o.alu_op = alu_dec(funct3, alt, 1'b0);
                ctrl_o.rf_we  = 1'b1;
                imm_o         = imm_i;
                re1_o         = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                ctrl_o.mem_en = 1'b1;
                ctrl_o.load   = 1'b1;
                ctrl_o.rf_we  = 1'b1;
                imm_o         = imm_i;
                re1_o         = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                ctrl_o.mem_en  = 1'b1;
                ctrl_o.mem_wen = 1'b1;
                imm_o          = imm_s;
                re1_o          = 1'b1;
                re2_o          = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl_o.alu_op   = id_pkg::ALU_SUB;
                ctrl_o.src2_sel = id_pkg::SRC2_RS2;
                ctrl_o.br_kind  = id_pkg::BR_COND;
                imm_o           = imm_b;
                re1_o           = 1'b1;
                re2_o           = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                // link value pc + 4
                ctrl_o.src1_sel = id_pkg::SRC1_PC;
                ctrl_o.src2_sel = id_pkg::SRC2_FOUR;
                ctrl_o.br_kind  = id_pkg::BR_JAL;
                ctrl_o.rf_we    = 1'b1;
                imm_o           = imm_j;
            end
            rv_pkg::OPC_JALR: begin
                ctrl_o.src1_sel = id_pkg::SRC1_PC;
                ctrl_o.src2_sel = id_pkg::SRC2_FOUR;
                ctrl_o.br_kind  = id_pkg::BR_JALR;
                ctrl_o.rf_we    = 1'b1;
                imm_o           = imm_i;
                re1_o           = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                ctrl_o.alu_op   = id_pkg::ALU_PASS_B;
                ctrl_o.src1_sel = id_pkg::SRC1_ZERO;
                ctrl_o.rf_we    = 1'b1;
                imm_o           = imm_u;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl_o.src1_sel = id_pkg::SRC1_PC;
                ctrl_o.rf_we    = 1'b1;
                imm_o           = imm_u;
            end
            default: begin
            end
        endcase

        // quiet during reset, no writes, no redirect, no hazard
        if (!rst_n_i) begin
            ctrl_o.rf_we   = 1'b0;
            ctrl_o.mem_en  = 1'b0;
            ctrl_o.mem_wen = 1'b0;
            ctrl_o.br_kind = id_pkg::BR_NONE;
            re1_o          = 1'b0;
            re2_o          = 1'b0;
        end
    end

endmodule

// ==== rtl/id_pkg.sv ====
package id_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // operand select codes
    typedef logic [1:0] src1_sel_e;
    localparam src1_sel_e SRC1_RS1  = 2'd0;
    localparam src1_sel_e SRC1_PC   = 2'd1;
    localparam src1_sel_e SRC1_ZERO = 2'd2;

    typedef logic [1:0] src2_sel_e;
    localparam src2_sel_e SRC2_RS2  = 2'd0;
    localparam src2_sel_e SRC2_IMM  = 2'd1;
    localparam src2_sel_e SRC2_FOUR = 2'd2;

    // control transfer kind
    typedef logic [1:0] br_kind_e;
    localparam br_kind_e BR_NONE = 2'd0;
    localparam br_kind_e BR_COND = 2'd1;
    localparam br_kind_e BR_JAL  = 2'd2;
    localparam br_kind_e BR_JALR = 2'd3;

    typedef struct packed {
        alu_op_e           alu_op;
        src1_sel_e         src1_sel;
        src2_sel_e         src2_sel;
        br_kind_e          br_kind;
        logic              mem_en;
        logic              mem_wen;
        rv_pkg::funct3_t   mem_size;
        logic              load;
        logic              rf_we;
        rv_pkg::reg_addr_t rf_waddr;
    } ctrl_t;

    // result bus returned by EX, MEM and WB
    typedef struct packed {
        logic              we;
        logic              load;
        rv_pkg::reg_addr_t waddr;
        rv_pkg::xlen_t     data;
    } byp_t;

endpackage

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    // architectural widths
    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes, base RV64I subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

endpackage
